// File: decode_defines.svh
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

`define XLEN    32
`define NREGS   32
`define RADDR_W 5

// 3R ops, fields 31:26, 25:22, 21:20, 19:15
`define OP_ADD_W    {6'h00, 4'h0, 2'h1, 5'h00}
`define OP_SUB_W    {6'h00, 4'h0, 2'h1, 5'h02}
`define OP_SLT      {6'h00, 4'h0, 2'h1, 5'h04}
`define OP_SLTU     {6'h00, 4'h0, 2'h1, 5'h05}
`define OP_NOR      {6'h00, 4'h0, 2'h1, 5'h08}
`define OP_AND      {6'h00, 4'h0, 2'h1, 5'h09}
`define OP_OR       {6'h00, 4'h0, 2'h1, 5'h0a}
`define OP_XOR      {6'h00, 4'h0, 2'h1, 5'h0b}
`define OP_SLL_W    {6'h00, 4'h0, 2'h1, 5'h0e}
`define OP_SRL_W    {6'h00, 4'h0, 2'h1, 5'h0f}
`define OP_SRA_W    {6'h00, 4'h0, 2'h1, 5'h10}
// shifts by ui5 share the 3R layout
`define OP_SLLI_W   {6'h00, 4'h1, 2'h0, 5'h01}
`define OP_SRLI_W   {6'h00, 4'h1, 2'h0, 5'h09}
`define OP_SRAI_W   {6'h00, 4'h1, 2'h0, 5'h11}
// 2RI12 ops, fields 31:26 and 25:22
`define OP_SLTI     {6'h00, 4'h8}
`define OP_SLTUI    {6'h00, 4'h9}
`define OP_ADDI_W   {6'h00, 4'ha}
`define OP_ANDI     {6'h00, 4'hd}
`define OP_ORI      {6'h00, 4'he}
`define OP_XORI     {6'h00, 4'hf}
`define OP_LD_W     {6'h0a, 4'h2}
`define OP_ST_W     {6'h0a, 4'h6}
// 1RI20 ops, field 31:26 plus bit 25
`define OP_LU12I_W  {6'h05, 1'b0}
`define OP_PCADDU12I {6'h07, 1'b0}
// jumps and branches, field 31:26 only
`define OP_JIRL     6'h13
`define OP_B        6'h14
`define OP_BL       6'h15
`define OP_BEQ      6'h16
`define OP_BNE      6'h17
`define OP_BLT      6'h18
`define OP_BGE      6'h19
`define OP_BLTU     6'h1a
`define OP_BGEU     6'h1b

`endif

// File: decode_pkg.sv
`default_nettype none

`include "decode_defines.svh"

package decode_pkg;

  typedef logic [`XLEN-1:0]    word_t;
  typedef logic [`RADDR_W-1:0] reg_addr_t;

  // one-hot alu operation
  typedef logic [11:0] alu_op_t;

  localparam int ALU_ADD  = 0;
  localparam int ALU_SUB  = 1;
  localparam int ALU_SLT  = 2;
  localparam int ALU_SLTU = 3;
  localparam int ALU_AND  = 4;
  localparam int ALU_NOR  = 5;
  localparam int ALU_OR   = 6;
  localparam int ALU_XOR  = 7;
  localparam int ALU_SLL  = 8;
  localparam int ALU_SRL  = 9;
  localparam int ALU_SRA  = 10;
  localparam int ALU_LUI  = 11;

  typedef enum logic [3:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE,
    BR_BLTU,
    BR_BGEU,
    BR_B,
    BR_BL,
    BR_JIRL
  } br_kind_t;

endpackage

`default_nettype wire

// File: inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_defines.svh"

module inst_decoder import decode_pkg::*; (
  input  wire word_t inst,
  output alu_op_t    alu_op,
  output logic       src1_is_pc,
  output logic       src2_is_imm,
  output word_t      imm,
  output reg_addr_t  rf_raddr1,
  output reg_addr_t  rf_raddr2,
  output logic       uses_rj,
  output logic       uses_rkd,
  output reg_addr_t  dest,
  output logic       gr_we,
  output logic       mem_we,
  output logic       res_from_mem,
  output br_kind_t   br_kind,
  output word_t      br_offs
);

  wire [16:0] op_3r    = inst[31:15];
  wire [9:0]  op_2ri12 = inst[31:22];
  wire [6:0]  op_1ri20 = inst[31:25];
  wire [5:0]  op_br    = inst[31:26];

  wire [4:0]  rd  = inst[4:0];
  wire [4:0]  rj  = inst[9:5];
  wire [4:0]  rk  = inst[14:10];
  wire [11:0] i12 = inst[21:10];
  wire [19:0] i20 = inst[24:5];
  wire [15:0] i16 = inst[25:10];
  wire [25:0] i26 = {inst[9:0], inst[25:10]};

  wire is_add_w     = (op_3r == `OP_ADD_W);
  wire is_sub_w     = (op_3r == `OP_SUB_W);
  wire is_slt       = (op_3r == `OP_SLT);
  wire is_sltu      = (op_3r == `OP_SLTU);
  wire is_nor       = (op_3r == `OP_NOR);
  wire is_and       = (op_3r == `OP_AND);
  wire is_or        = (op_3r == `OP_OR);
  wire is_xor       = (op_3r == `OP_XOR);
  wire is_sll_w     = (op_3r == `OP_SLL_W);
  wire is_srl_w     = (op_3r == `OP_SRL_W);
  wire is_sra_w     = (op_3r == `OP_SRA_W);
  wire is_slli_w    = (op_3r == `OP_SLLI_W);
  wire is_srli_w    = (op_3r == `OP_SRLI_W);
  wire is_srai_w    = (op_3r == `OP_SRAI_W);
  wire is_slti      = (op_2ri12 == `OP_SLTI);
  wire is_sltui     = (op_2ri12 == `OP_SLTUI);
  wire is_addi_w    = (op_2ri12 == `OP_ADDI_W);
  wire is_andi      = (op_2ri12 == `OP_ANDI);
  wire is_ori       = (op_2ri12 == `OP_ORI);
  wire is_xori      = (op_2ri12 == `OP_XORI);
  wire is_ld_w      = (op_2ri12 == `OP_LD_W);
  wire is_st_w      = (op_2ri12 == `OP_ST_W);
  wire is_lu12i_w   = (op_1ri20 == `OP_LU12I_W);
  wire is_pcaddu12i = (op_1ri20 == `OP_PCADDU12I);
  wire is_jirl      = (op_br == `OP_JIRL);
  wire is_b         = (op_br == `OP_B);
  wire is_bl        = (op_br == `OP_BL);
  wire is_beq       = (op_br == `OP_BEQ);
  wire is_bne       = (op_br == `OP_BNE);
  wire is_blt       = (op_br == `OP_BLT);
  wire is_bge       = (op_br == `OP_BGE);
  wire is_bltu      = (op_br == `OP_BLTU);
  wire is_bgeu      = (op_br == `OP_BGEU);

  // format groups
  wire is_alu_3r  = is_add_w | is_sub_w | is_slt | is_sltu | is_nor | is_and | is_or
                  | is_xor | is_sll_w | is_srl_w | is_sra_w;
  wire is_shift_i = is_slli_w | is_srli_w | is_srai_w;
  wire is_si12    = is_addi_w | is_slti | is_sltui | is_ld_w | is_st_w;
  wire is_ui12    = is_andi | is_ori | is_xori;
  wire is_u20     = is_lu12i_w | is_pcaddu12i;
  wire is_cond_br = is_beq | is_bne | is_blt | is_bge | is_bltu | is_bgeu;
  wire is_link    = is_bl | is_jirl;

  assign alu_op[ALU_ADD]  = is_add_w | is_addi_w | is_ld_w | is_st_w | is_link | is_pcaddu12i;
  assign alu_op[ALU_SUB]  = is_sub_w;
  assign alu_op[ALU_SLT]  = is_slt | is_slti;
  assign alu_op[ALU_SLTU] = is_sltu | is_sltui;
  assign alu_op[ALU_AND]  = is_and | is_andi;
  assign alu_op[ALU_NOR]  = is_nor;
  assign alu_op[ALU_OR]   = is_or | is_ori;
  assign alu_op[ALU_XOR]  = is_xor | is_xori;
  assign alu_op[ALU_SLL]  = is_sll_w | is_slli_w;
  assign alu_op[ALU_SRL]  = is_srl_w | is_srli_w;
  assign alu_op[ALU_SRA]  = is_sra_w | is_srai_w;
  assign alu_op[ALU_LUI]  = is_lu12i_w;

  assign src1_is_pc  = is_link | is_pcaddu12i;
  assign src2_is_imm = is_shift_i | is_si12 | is_ui12 | is_u20 | is_link;

  always_comb begin
    if (is_link) begin
      // link address is pc + 4
      imm = word_t'(4);
    end else if (is_u20) begin
      imm = {i20, 12'b0};
    end else if (is_shift_i) begin
      imm = {27'b0, rk};
    end else if (is_si12) begin
      imm = {{20{i12[11]}}, i12};
    end else if (is_ui12) begin
      imm = {20'b0, i12};
    end else begin
      imm = '0;
    end
  end

  assign br_offs = (is_b | is_bl) ? {{4{i26[25]}}, i26, 2'b0} : {{14{i16[15]}}, i16, 2'b0};

  // branches and stores read rd on the second port
  assign rf_raddr1 = rj;
  assign rf_raddr2 = (is_cond_br | is_st_w) ? rd : rk;
  assign uses_rj   = is_alu_3r | is_shift_i | is_si12 | is_ui12 | is_cond_br | is_jirl;
  assign uses_rkd  = is_alu_3r | is_st_w | is_cond_br;

  assign gr_we = is_alu_3r | is_shift_i | (is_si12 & ~is_st_w) | is_ui12 | is_u20 | is_link;
  assign dest  = is_bl ? 5'd1 : rd;
  assign mem_we       = is_st_w;
  assign res_from_mem = is_ld_w;

  always_comb begin
    br_kind = BR_NONE;
    if (is_beq)  br_kind = BR_BEQ;
    if (is_bne)  br_kind = BR_BNE;
    if (is_blt)  br_kind = BR_BLT;
    if (is_bge)  br_kind = BR_BGE;
    if (is_bltu) br_kind = BR_BLTU;
    if (is_bgeu) br_kind = BR_BGEU;
    if (is_b)    br_kind = BR_B;
    if (is_bl)   br_kind = BR_BL;
    if (is_jirl) br_kind = BR_JIRL;
  end

endmodule

`default_nettype wire

// File: regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_defines.svh"

module regfile import decode_pkg::*; (
  input  wire            clk,
  input  wire reg_addr_t raddr1,
  input  wire reg_addr_t raddr2,
  input  wire            we,
  input  wire reg_addr_t waddr,
  input  wire word_t     wdata,
  output word_t          rdata1,
  output word_t          rdata2
);

  word_t regs [`NREGS];

  always_ff @(posedge clk) begin
    if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // r0 is hardwired to zero
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: operand_bypass.sv
`timescale 1ns/1ns
`default_nettype none

module operand_bypass import decode_pkg::*; (
  input  wire            clk,
  input  wire reg_addr_t rf_raddr1,
  input  wire reg_addr_t rf_raddr2,
  input  wire            exe_we,
  input  wire reg_addr_t exe_dest,
  input  wire word_t     exe_result,
  input  wire            mem_we,
  input  wire reg_addr_t mem_dest,
  input  wire word_t     mem_result,
  input  wire            wb_we,
  input  wire reg_addr_t wb_dest,
  input  wire word_t     wb_data,
  output word_t          rj_value,
  output word_t          rkd_value
);

  word_t rf_rdata1;
  word_t rf_rdata2;

  regfile u_regfile (
    .clk    (clk),
    .raddr1 (rf_raddr1),
    .raddr2 (rf_raddr2),
    .we     (wb_we),
    .waddr  (wb_dest),
    .wdata  (wb_data),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2)
  );

  // youngest producer wins
  function automatic word_t pick(input reg_addr_t addr, input word_t rf_data);
    word_t value;
    value = rf_data;
    if (addr != '0) begin
      if (exe_we && (exe_dest == addr)) begin
        value = exe_result;
      end else if (mem_we && (mem_dest == addr)) begin
        value = mem_result;
      end else if (wb_we && (wb_dest == addr)) begin
        value = wb_data;
      end
    end
    return value;
  endfunction

  always_comb begin
    rj_value  = pick(rf_raddr1, rf_rdata1);
    rkd_value = pick(rf_raddr2, rf_rdata2);
  end

  // no stage may forward into r0
  a_r0_zero: assert property (@(posedge clk)
    ((rf_raddr1 != '0) || (rj_value == '0)) && ((rf_raddr2 != '0) || (rkd_value == '0)));

endmodule

`default_nettype wire

// File: branch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module branch_unit import decode_pkg::*; (
  input  wire br_kind_t br_kind,
  input  wire word_t    br_offs,
  input  wire word_t    pc,
  input  wire word_t    rj_value,
  input  wire word_t    rkd_value,
  input  wire           ds_fire,
  output logic          br_taken,
  output word_t         br_target
);

  localparam int W = $bits(word_t);

  logic [W:0] diff;
  logic       carry;
  logic       rj_eq;
  logic       rj_lt;
  logic       rj_ltu;
  logic       cond;

  // rj - rkd, carry out set means no borrow
  assign diff   = {1'b0, rj_value} + {1'b0, ~rkd_value} + 1'b1;
  assign carry  = diff[W];
  assign rj_eq  = (diff[W-1:0] == '0);
  assign rj_ltu = ~carry;
  // top bit of the sign-extended difference
  assign rj_lt  = rj_value[W-1] ^ ~rkd_value[W-1] ^ carry;

  always_comb begin
    case (br_kind)
      BR_BEQ:  cond = rj_eq;
      BR_BNE:  cond = ~rj_eq;
      BR_BLT:  cond = rj_lt;
      BR_BGE:  cond = ~rj_lt;
      BR_BLTU: cond = rj_ltu;
      BR_BGEU: cond = ~rj_ltu;
      BR_B, BR_BL, BR_JIRL: cond = 1'b1;
      default: cond = 1'b0;
    endcase
  end

  // only meaningful while the instruction leaves
  assign br_taken  = cond && ds_fire;
  assign br_target = ((br_kind == BR_JIRL) ? rj_value : pc) + br_offs;

endmodule

`default_nettype wire

// File: issue_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module issue_ctrl import decode_pkg::*; (
  input  wire            clk,
  input  wire            rst,
  input  wire            fs_valid,
  input  wire word_t     fs_pc,
  input  wire word_t     fs_inst,
  input  wire            es_allowin,
  input  wire            br_taken,
  input  wire reg_addr_t rf_raddr1,
  input  wire reg_addr_t rf_raddr2,
  input  wire            uses_rj,
  input  wire            uses_rkd,
  input  wire            exe_we,
  input  wire reg_addr_t exe_dest,
  input  wire            exe_is_load,
  output logic           ds_allowin,
  output logic           es_valid,
  output logic           ds_fire,
  output word_t          ds_pc,
  output word_t          ds_inst
);

  logic ds_valid;
  logic hit_rj;
  logic hit_rkd;
  logic load_use;

  // load data is not ready until memory stage
  assign hit_rj   = uses_rj && (exe_dest == rf_raddr1);
  assign hit_rkd  = uses_rkd && (exe_dest == rf_raddr2);
  assign load_use = exe_we && exe_is_load && (exe_dest != '0) && (hit_rj || hit_rkd);

  assign es_valid   = ds_valid && !load_use;
  assign ds_fire    = es_valid && es_allowin;
  assign ds_allowin = !ds_valid || ds_fire;

  always_ff @(posedge clk) begin
    if (rst) begin
      ds_valid <= 1'b0;
    end else if (br_taken) begin
      // wrong-path fetch is dropped
      ds_valid <= 1'b0;
    end else if (ds_allowin) begin
      ds_valid <= fs_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fs_valid && ds_allowin) begin
      ds_pc   <= fs_pc;
      ds_inst <= fs_inst;
    end
  end

  // branch unit may only redirect on a leaving instruction
  a_br_fire: assert property (@(posedge clk) disable iff (rst) br_taken |-> ds_fire);

endmodule

`default_nettype wire

// File: decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage import decode_pkg::*; (
  input  wire            clk,
  input  wire            rst,
  input  wire            fs_valid,
  input  wire word_t     fs_pc,
  input  wire word_t     fs_inst,
  input  wire            es_allowin,
  input  wire            exe_we,
  input  wire reg_addr_t exe_dest,
  input  wire word_t     exe_result,
  input  wire            exe_is_load,
  input  wire            mem_rf_we,
  input  wire reg_addr_t mem_dest,
  input  wire word_t     mem_result,
  input  wire            wb_we,
  input  wire reg_addr_t wb_dest,
  input  wire word_t     wb_data,
  output logic           ds_allowin,
  output logic           es_valid,
  output word_t          es_pc,
  output alu_op_t        alu_op,
  output word_t          alu_src1,
  output word_t          alu_src2,
  output word_t          rkd_value,
  output logic           gr_we,
  output reg_addr_t      dest,
  output logic           mem_we,
  output logic           res_from_mem,
  output logic           br_taken,
  output word_t          br_target
);

  word_t     ds_pc;
  word_t     ds_inst;
  logic      ds_fire;
  logic      src1_is_pc;
  logic      src2_is_imm;
  word_t     imm;
  reg_addr_t rf_raddr1;
  reg_addr_t rf_raddr2;
  logic      uses_rj;
  logic      uses_rkd;
  br_kind_t  br_kind;
  word_t     br_offs;
  word_t     rj_value;

  issue_ctrl u_issue_ctrl (
    .clk, .rst, .fs_valid, .fs_pc, .fs_inst, .es_allowin, .br_taken,
    .rf_raddr1, .rf_raddr2, .uses_rj, .uses_rkd, .exe_we, .exe_dest, .exe_is_load,
    .ds_allowin, .es_valid, .ds_fire, .ds_pc, .ds_inst
  );

  inst_decoder u_inst_decoder (
    .inst (ds_inst),
    .alu_op, .src1_is_pc, .src2_is_imm, .imm, .rf_raddr1, .rf_raddr2, .uses_rj,
    .uses_rkd, .dest, .gr_we, .mem_we, .res_from_mem, .br_kind, .br_offs
  );

  operand_bypass u_operand_bypass (
    .clk, .rf_raddr1, .rf_raddr2, .exe_we, .exe_dest, .exe_result,
    .mem_we (mem_rf_we), .mem_dest, .mem_result, .wb_we, .wb_dest, .wb_data,
    .rj_value, .rkd_value
  );

  branch_unit u_branch_unit (
    .br_kind, .br_offs, .pc (ds_pc), .rj_value, .rkd_value, .ds_fire,
    .br_taken, .br_target
  );

  assign es_pc    = ds_pc;
  // execute operands
  assign alu_src1 = src1_is_pc ? ds_pc : rj_value;
  assign alu_src2 = src2_is_imm ? imm : rkd_value;

endmodule

`default_nettype wire

// File: tb_decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_defines.svh"

module tb_decode_stage import decode_pkg::*; ();

  localparam int    MAX_CYCLES = 2000;
  localparam word_t PC0        = 32'h1c00_0100;

  logic      clk;
  logic      rst;
  logic      fs_valid;
  word_t     fs_pc;
  word_t     fs_inst;
  logic      es_allowin;
  logic      exe_we;
  reg_addr_t exe_dest;
  word_t     exe_result;
  logic      exe_is_load;
  logic      mem_rf_we;
  reg_addr_t mem_dest;
  word_t     mem_result;
  logic      wb_we;
  reg_addr_t wb_dest;
  word_t     wb_data;
  logic      ds_allowin;
  logic      es_valid;
  word_t     es_pc;
  alu_op_t   alu_op;
  word_t     alu_src1;
  word_t     alu_src2;
  word_t     rkd_value;
  logic      gr_we;
  reg_addr_t dest;
  logic      mem_we;
  logic      res_from_mem;
  logic      br_taken;
  word_t     br_target;

  int    seed = 54533;
  int    errors = 0;
  int    test_errors = 0;
  int    checks = 0;
  int    tests = 0;
  int    cycles = 0;
  word_t rf_model [`NREGS];

  decode_stage dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("run stopped after %0d cycles without reaching the end of the tests", cycles);
    $display("Something failed");
    $finish;
  end

  // instruction formats
  function automatic word_t enc_3r(input logic [16:0] op, input reg_addr_t rk,
                                   input reg_addr_t rj, input reg_addr_t rd);
    return {op, rk, rj, rd};
  endfunction

  function automatic word_t enc_2ri12(input logic [9:0] op, input logic [11:0] i12,
                                      input reg_addr_t rj, input reg_addr_t rd);
    return {op, i12, rj, rd};
  endfunction

  function automatic word_t enc_1ri20(input logic [6:0] op, input logic [19:0] i20,
                                      input reg_addr_t rd);
    return {op, i20, rd};
  endfunction

  function automatic word_t enc_br16(input logic [5:0] op, input logic [15:0] offs,
                                     input reg_addr_t rj, input reg_addr_t rd);
    return {op, offs, rj, rd};
  endfunction

  function automatic word_t enc_br26(input logic [5:0] op, input logic [25:0] offs);
    return {op, offs[15:0], offs[25:16]};
  endfunction

  function automatic alu_op_t onehot(input int idx);
    return alu_op_t'(12'b1 << idx);
  endfunction

  task automatic check(input string name, input word_t got, input word_t exp);
    checks++;
    assert (got === exp) else begin
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_test(input string name);
    tests++;
    if (test_errors == 0) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: %0d checks failed", name, test_errors);
    end
    test_errors = 0;
  endtask

  // preload through the writeback port
  task automatic load_reg(input reg_addr_t addr, input word_t value);
    @(posedge clk);
    wb_we   <= 1'b1;
    wb_dest <= addr;
    wb_data <= value;
    @(posedge clk);
    wb_we <= 1'b0;
    rf_model[addr] = value;
  endtask

  task automatic wait_allowin();
    @(negedge clk);
    while (!ds_allowin) @(negedge clk);
  endtask

  // returns on the edge that accepts the instruction
  task automatic send(input word_t inst, input word_t pc);
    @(posedge clk);
    fs_valid <= 1'b1;
    fs_pc    <= pc;
    fs_inst  <= inst;
    wait_allowin();
    @(posedge clk);
    fs_valid <= 1'b0;
  endtask

  // keeps fetch busy with a wrong-path instruction after the branch
  task automatic send_then_follow(input word_t inst, input word_t pc, input word_t next_inst);
    @(posedge clk);
    fs_valid <= 1'b1;
    fs_pc    <= pc;
    fs_inst  <= inst;
    wait_allowin();
    @(posedge clk);
    fs_pc   <= pc + 32'd4;
    fs_inst <= next_inst;
  endtask

  task automatic check_discard();
    @(posedge clk);
    fs_valid <= 1'b0;
    repeat (2) begin
      @(negedge clk);
      check("es_valid", es_valid, 0);
    end
  endtask

  task automatic check_decode(input word_t inst, input alu_op_t op, input word_t src1,
                              input word_t src2, input reg_addr_t rd, input logic we,
                              input logic mw, input logic rfm, input logic [1:0] chk);
    send(inst, PC0);
    @(negedge clk);
    check("es_valid", es_valid, 1);
    check("es_pc", es_pc, PC0);
    check("alu_op", alu_op, op);
    if (chk[0]) check("alu_src1", alu_src1, src1);
    if (chk[1]) check("alu_src2", alu_src2, src2);
    if (we) check("dest", dest, rd);
    check("gr_we", gr_we, we);
    check("mem_we", mem_we, mw);
    check("res_from_mem", res_from_mem, rfm);
    check("br_taken", br_taken, 0);
  endtask

  task automatic test_reset();
    @(negedge clk);
    check("es_valid", es_valid, 0);
    check("br_taken", br_taken, 0);
    check("ds_allowin", ds_allowin, 1);
    report_test("reset");
  endtask

  task automatic test_decode();
    word_t a;
    word_t b;
    word_t s12;
    word_t u12;
    a = $random(seed);
    b = $random(seed);
    s12 = 32'hffff_ff80;
    u12 = 32'h0000_0f80;
    load_reg(3, a);
    load_reg(4, b);
    check_decode(enc_3r(`OP_ADD_W, 4, 3, 5), onehot(ALU_ADD), a, b, 5, 1, 0, 0, 2'b11);
    check_decode(enc_3r(`OP_SUB_W, 4, 3, 5), onehot(ALU_SUB), a, b, 5, 1, 0, 0, 2'b11);
    check_decode(enc_3r(`OP_SLT, 4, 3, 5), onehot(ALU_SLT), a, b, 5, 1, 0, 0, 2'b11);
    check_decode(enc_3r(`OP_SLTU, 4, 3, 5), onehot(ALU_SLTU), a, b, 5, 1, 0, 0, 2'b11);
    check_decode(enc_3r(`OP_AND, 4, 3, 5), onehot(ALU_AND), a, b, 5, 1, 0, 0, 2'b11);
    check_decode(enc_3r(`OP_OR, 4, 3, 5), onehot(ALU_OR), a, b, 5, 1, 0, 0, 2'b11);
    check_decode(enc_3r(`OP_NOR, 4, 3, 5), onehot(ALU_NOR), a, b, 5, 1, 0, 0, 2'b11);
    check_decode(enc_3r(`OP_XOR, 4, 3, 5), onehot(ALU_XOR), a, b, 5, 1, 0, 0, 2'b11);
    check_decode(enc_3r(`OP_SLL_W, 4, 3, 5), onehot(ALU_SLL), a, b, 5, 1, 0, 0, 2'b11);
    check_decode(enc_3r(`OP_SRL_W, 4, 3, 5), onehot(ALU_SRL), a, b, 5, 1, 0, 0, 2'b11);
    check_decode(enc_3r(`OP_SRA_W, 4, 3, 5), onehot(ALU_SRA), a, b, 5, 1, 0, 0, 2'b11);
    // ui5 sits in the rk field
    check_decode(enc_3r(`OP_SLLI_W, 7, 3, 5), onehot(ALU_SLL), a, 7, 5, 1, 0, 0, 2'b11);
    check_decode(enc_3r(`OP_SRLI_W, 7, 3, 5), onehot(ALU_SRL), a, 7, 5, 1, 0, 0, 2'b11);
    check_decode(enc_3r(`OP_SRAI_W, 7, 3, 5), onehot(ALU_SRA), a, 7, 5, 1, 0, 0, 2'b11);
    check_decode(enc_2ri12(`OP_ADDI_W, 12'hf80, 3, 5), onehot(ALU_ADD), a, s12, 5, 1, 0, 0,
                 2'b11);
    check_decode(enc_2ri12(`OP_SLTI, 12'hf80, 3, 5), onehot(ALU_SLT), a, s12, 5, 1, 0, 0, 2'b11);
    check_decode(enc_2ri12(`OP_SLTUI, 12'hf80, 3, 5), onehot(ALU_SLTU), a, s12, 5, 1, 0, 0,
                 2'b11);
    check_decode(enc_2ri12(`OP_ANDI, 12'hf80, 3, 5), onehot(ALU_AND), a, u12, 5, 1, 0, 0, 2'b11);
    check_decode(enc_2ri12(`OP_ORI, 12'hf80, 3, 5), onehot(ALU_OR), a, u12, 5, 1, 0, 0, 2'b11);
    check_decode(enc_2ri12(`OP_XORI, 12'hf80, 3, 5), onehot(ALU_XOR), a, u12, 5, 1, 0, 0, 2'b11);
    check_decode(enc_1ri20(`OP_LU12I_W, 20'h12345, 5), onehot(ALU_LUI), 0, 32'h1234_5000, 5,
                 1, 0, 0, 2'b10);
    check_decode(enc_1ri20(`OP_PCADDU12I, 20'habcde, 5), onehot(ALU_ADD), PC0, 32'habcd_e000,
                 5, 1, 0, 0, 2'b11);
    check_decode(enc_2ri12(`OP_LD_W, 12'hf80, 3, 5), onehot(ALU_ADD), a, s12, 5, 1, 0, 1, 2'b11);
    check_decode(enc_2ri12(`OP_ST_W, 12'hf80, 3, 4), onehot(ALU_ADD), a, s12, 4, 0, 1, 0, 2'b11);
    // store data comes from rd
    check("rkd_value", rkd_value, b);
    check_decode(32'hffff_ffff, '0, 0, 0, 0, 0, 0, 0, 2'b00);
    report_test("decode");
  endtask

  task automatic test_bypass();
    word_t v0;
    word_t ve;
    word_t vm;
    word_t vw;
    word_t vw_next;
    v0 = $random(seed);
    ve = $random(seed);
    vm = $random(seed);
    vw = $random(seed);
    vw_next = $random(seed);
    load_reg(6, v0);
    @(posedge clk);
    es_allowin <= 1'b0;
    send(enc_3r(`OP_ADD_W, 0, 6, 5), PC0);
    exe_we     <= 1'b1;
    exe_dest   <= 6;
    exe_result <= ve;
    mem_rf_we  <= 1'b1;
    mem_dest   <= 6;
    mem_result <= vm;
    wb_we      <= 1'b1;
    wb_dest    <= 6;
    wb_data    <= vw;
    rf_model[6] = vw;
    @(negedge clk);
    check("alu_src1", alu_src1, ve);
    check("alu_src2", alu_src2, 0);
    @(posedge clk);
    exe_we <= 1'b0;
    @(negedge clk);
    check("alu_src1", alu_src1, vm);
    // register file holds vw by now, so writeback carries a fresh value
    @(posedge clk);
    mem_rf_we <= 1'b0;
    wb_data   <= vw_next;
    @(negedge clk);
    check("alu_src1", alu_src1, vw_next);
    @(posedge clk);
    wb_we   <= 1'b0;
    wb_data <= vw;
    rf_model[6] = vw_next;
    @(negedge clk);
    check("alu_src1", alu_src1, rf_model[6]);
    // every stage aimed at r0
    @(posedge clk);
    exe_we    <= 1'b1;
    exe_dest  <= 0;
    mem_rf_we <= 1'b1;
    mem_dest  <= 0;
    wb_we     <= 1'b1;
    wb_dest   <= 0;
    @(negedge clk);
    check("alu_src2", alu_src2, 0);
    check("alu_src1", alu_src1, rf_model[6]);
    @(posedge clk);
    exe_we     <= 1'b0;
    mem_rf_we  <= 1'b0;
    wb_we      <= 1'b0;
    es_allowin <= 1'b1;
    @(negedge clk);
    check("es_valid", es_valid, 1);
    report_test("bypass");
  endtask

  task automatic test_load_use();
    word_t vl;
    vl = $random(seed);
    @(posedge clk);
    exe_we      <= 1'b1;
    exe_is_load <= 1'b1;
    exe_dest    <= 6;
    exe_result  <= vl;
    send(enc_3r(`OP_ADD_W, 4, 6, 5), PC0);
    repeat (3) begin
      @(negedge clk);
      check("es_valid", es_valid, 0);
      check("ds_allowin", ds_allowin, 0);
    end
    @(posedge clk);
    exe_is_load <= 1'b0;
    @(negedge clk);
    check("es_valid", es_valid, 1);
    check("alu_src1", alu_src1, vl);
    @(posedge clk);
    exe_we <= 1'b0;
    report_test("load_use");
  endtask

  task automatic test_cond_branches();
    logic [5:0]  br_ops [6];
    word_t       a;
    word_t       b;
    word_t       tgt;
    logic [15:0] offs;
    logic        exp;
    br_ops = '{`OP_BEQ, `OP_BNE, `OP_BLT, `OP_BGE, `OP_BLTU, `OP_BGEU};
    for (int k = 0; k < 6; k++) begin
      for (int n = 0; n < 4; n++) begin
        a = $random(seed);
        b = (n == 0) ? a : $random(seed);
        // flipped sign bit so signed and unsigned order disagree
        if (n == 1) b = {~a[31], a[30:0]};
        offs = $random(seed);
        load_reg(7, a);
        load_reg(8, b);
        tgt = PC0 + {{14{offs[15]}}, offs, 2'b00};
        case (k)
          0: exp = (a == b);
          1: exp = (a != b);
          2: exp = ($signed(a) < $signed(b));
          3: exp = ($signed(a) >= $signed(b));
          4: exp = (a < b);
          default: exp = (a >= b);
        endcase
        send(enc_br16(br_ops[k], offs, 7, 8), PC0);
        @(negedge clk);
        check("es_valid", es_valid, 1);
        check("br_taken", br_taken, exp);
        if (exp) check("br_target", br_target, tgt);
      end
    end
    report_test("cond_branches");
  endtask

  task automatic test_jumps();
    word_t       a;
    word_t       follow;
    logic [25:0] offs26;
    logic [15:0] offs16;
    a = $random(seed);
    offs26 = $random(seed);
    offs16 = $random(seed);
    follow = enc_3r(`OP_ADD_W, 4, 3, 5);
    load_reg(7, a);
    send_then_follow(enc_br26(`OP_B, offs26), PC0, follow);
    @(negedge clk);
    check("br_taken", br_taken, 1);
    check("br_target", br_target, PC0 + {{4{offs26[25]}}, offs26, 2'b00});
    check("gr_we", gr_we, 0);
    check_discard();
    send_then_follow(enc_br26(`OP_BL, offs26), PC0, follow);
    @(negedge clk);
    check("br_taken", br_taken, 1);
    check("br_target", br_target, PC0 + {{4{offs26[25]}}, offs26, 2'b00});
    check("gr_we", gr_we, 1);
    check("dest", dest, 1);
    check("alu_op", alu_op, onehot(ALU_ADD));
    check("alu_src1", alu_src1, PC0);
    check("alu_src2", alu_src2, 4);
    check_discard();
    send_then_follow(enc_br16(`OP_JIRL, offs16, 7, 1), PC0, follow);
    @(negedge clk);
    check("br_taken", br_taken, 1);
    check("br_target", br_target, a + {{14{offs16[15]}}, offs16, 2'b00});
    check("dest", dest, 1);
    check("alu_src1", alu_src1, PC0);
    check("alu_src2", alu_src2, 4);
    check_discard();
    report_test("jumps");
  endtask

  task automatic test_backpressure();
    word_t       a;
    logic [15:0] offs;
    a = $random(seed);
    offs = $random(seed);
    load_reg(7, a);
    @(posedge clk);
    es_allowin <= 1'b0;
    // beq r7, r7 is always taken once it can leave
    send(enc_br16(`OP_BEQ, offs, 7, 7), PC0);
    repeat (4) begin
      @(negedge clk);
      check("es_valid", es_valid, 1);
      check("ds_allowin", ds_allowin, 0);
      check("br_taken", br_taken, 0);
      check("es_pc", es_pc, PC0);
      check("alu_src1", alu_src1, a);
      check("alu_src2", alu_src2, a);
    end
    @(posedge clk);
    es_allowin <= 1'b1;
    @(negedge clk);
    check("br_taken", br_taken, 1);
    check("br_target", br_target, PC0 + {{14{offs[15]}}, offs, 2'b00});
    @(negedge clk);
    check("es_valid", es_valid, 0);
    check("ds_allowin", ds_allowin, 1);
    report_test("backpressure");
  endtask

  initial begin
    rst         = 1'b1;
    fs_valid    = 1'b0;
    fs_pc       = '0;
    fs_inst     = '0;
    es_allowin  = 1'b1;
    exe_we      = 1'b0;
    exe_dest    = '0;
    exe_result  = '0;
    exe_is_load = 1'b0;
    mem_rf_we   = 1'b0;
    mem_dest    = '0;
    mem_result  = '0;
    wb_we       = 1'b0;
    wb_dest     = '0;
    wb_data     = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    test_reset();
    test_decode();
    test_bypass();
    test_load_use();
    test_cond_branches();
    test_jumps();
    test_backpressure();
    @(posedge clk);
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
decode_pkg.sv
inst_decoder.sv
regfile.sv
operand_bypass.sv
branch_unit.sv
issue_ctrl.sv
decode_stage.sv
tb_decode_stage.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module tb_decode_stage -o sim_decode
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_decode > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Everything OK" sim.log; then
  exit 0
fi
exit 1
